// File: hw/bus_cfg.svh
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// bus widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32
// one strobe bit per byte lane
`define BUS_STRB_W (`BUS_DATA_W / 8)

// sram geometry, 1 KiB window
`define SRAM_WORDS 256
`define SRAM_BASE  32'h0000_0000
`define SRAM_SPAN  32'h0000_0400

// timer window with two word registers
`define TIMER_BASE      32'h1000_0000
`define TIMER_SPAN      32'h0000_0008
`define TIMER_COUNT_OFS 4'h0
`define TIMER_CTRL_OFS  4'h4

`endif

// File: hw/bus_pkg.sv
`default_nettype none

`include "bus_cfg.svh"

package bus_pkg;

    typedef logic [`BUS_ADDR_W-1:0] addr_t;
    typedef logic [`BUS_DATA_W-1:0] data_t;
    typedef logic [`BUS_STRB_W-1:0] strb_t;
    typedef logic [1:0]             resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // master to slave, all five channels
    typedef struct packed {
        addr_t araddr;
        logic  arvalid;
        logic  rready;
        addr_t awaddr;
        logic  awvalid;
        data_t wdata;
        strb_t wstrb;
        logic  wvalid;
        logic  bready;
    } axi_req_t;

    // slave to master
    typedef struct packed {
        logic  arready;
        data_t rdata;
        resp_t rresp;
        logic  rvalid;
        logic  awready;
        logic  wready;
        resp_t bresp;
        logic  bvalid;
    } axi_resp_t;

endpackage

`default_nettype wire

// File: hw/bus_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    input  bus_pkg::axi_req_t  fetch_req,
    output bus_pkg::axi_resp_t fetch_resp,
    input  bus_pkg::axi_req_t  lsu_req,
    output bus_pkg::axi_resp_t lsu_resp,
    output bus_pkg::axi_req_t  arb_req,
    input  bus_pkg::axi_resp_t arb_resp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH_RD,
        ST_LSU_RD,
        ST_LSU_WR
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   rd_done;
    logic   wr_done;

    // response handshakes on the shared side end a grant
    assign rd_done = arb_resp.rvalid & arb_req.rready;
    assign wr_done = arb_resp.bvalid & arb_req.bready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // lsu over fetch, lsu write before lsu read
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (lsu_req.awvalid) begin
                    state_nxt = ST_LSU_WR;
                end else if (lsu_req.arvalid) begin
                    state_nxt = ST_LSU_RD;
                end else if (fetch_req.arvalid) begin
                    state_nxt = ST_FETCH_RD;
                end
            end
            ST_FETCH_RD, ST_LSU_RD: begin
                if (rd_done) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_LSU_WR: begin
                if (wr_done) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    // only the channels of the granted transaction pass through
    always_comb begin
        arb_req    = '0;
        fetch_resp = '0;
        lsu_resp   = '0;
        case (state)
            ST_FETCH_RD: begin
                arb_req.araddr     = fetch_req.araddr;
                arb_req.arvalid    = fetch_req.arvalid;
                arb_req.rready     = fetch_req.rready;
                fetch_resp.arready = arb_resp.arready;
                fetch_resp.rdata   = arb_resp.rdata;
                fetch_resp.rresp   = arb_resp.rresp;
                fetch_resp.rvalid  = arb_resp.rvalid;
            end
            ST_LSU_RD: begin
                arb_req.araddr   = lsu_req.araddr;
                arb_req.arvalid  = lsu_req.arvalid;
                arb_req.rready   = lsu_req.rready;
                lsu_resp.arready = arb_resp.arready;
                lsu_resp.rdata   = arb_resp.rdata;
                lsu_resp.rresp   = arb_resp.rresp;
                lsu_resp.rvalid  = arb_resp.rvalid;
            end
            ST_LSU_WR: begin
                arb_req.awaddr   = lsu_req.awaddr;
                arb_req.awvalid  = lsu_req.awvalid;
                arb_req.wdata    = lsu_req.wdata;
                arb_req.wstrb    = lsu_req.wstrb;
                arb_req.wvalid   = lsu_req.wvalid;
                arb_req.bready   = lsu_req.bready;
                lsu_resp.awready = arb_resp.awready;
                lsu_resp.wready  = arb_resp.wready;
                lsu_resp.bresp   = arb_resp.bresp;
                lsu_resp.bvalid  = arb_resp.bvalid;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/bus_xbar.sv
`timescale 1ns/10ps
`default_nettype none

`include "bus_cfg.svh"

module bus_xbar (
    input  logic               clk,
    input  logic               rst_n,
    input  bus_pkg::axi_req_t  arb_req,
    output bus_pkg::axi_resp_t arb_resp,
    output bus_pkg::axi_req_t  sram_req,
    input  bus_pkg::axi_resp_t sram_resp,
    output bus_pkg::axi_req_t  timer_req,
    input  bus_pkg::axi_resp_t timer_resp
);

    import bus_pkg::*;

    typedef enum logic [1:0] {
        TGT_SRAM,
        TGT_TIMER,
        TGT_ERR
    } tgt_e;

    tgt_e      sel;
    tgt_e      cur_tgt;
    logic      busy;
    logic      err_r;
    logic      err_b;
    logic      ar_hs;
    logic      aw_hs;
    logic      rsp_hs;
    axi_resp_t err_resp;
    axi_resp_t mux_resp;

    function automatic tgt_e decode(input addr_t addr);
        if ((addr & ~(`SRAM_SPAN - 1)) == `SRAM_BASE) begin
            return TGT_SRAM;
        end
        if ((addr & ~(`TIMER_SPAN - 1)) == `TIMER_BASE) begin
            return TGT_TIMER;
        end
        return TGT_ERR;
    endfunction

    // address valids only before the handshake, response readies only after
    function automatic axi_req_t gate_req(input axi_req_t r, input logic addr_en,
                                          input logic rsp_en);
        axi_req_t g;
        g         = r;
        g.arvalid = r.arvalid & addr_en;
        g.awvalid = r.awvalid & addr_en;
        g.wvalid  = r.wvalid & addr_en;
        g.rready  = r.rready & rsp_en;
        g.bready  = r.bready & rsp_en;
        return g;
    endfunction

    // latched target steers the response phase
    assign cur_tgt = busy ? sel :
                     (arb_req.arvalid ? decode(arb_req.araddr) : decode(arb_req.awaddr));

    assign sram_req  = gate_req(arb_req, !busy && cur_tgt == TGT_SRAM,
                                busy && cur_tgt == TGT_SRAM);
    assign timer_req = gate_req(arb_req, !busy && cur_tgt == TGT_TIMER,
                                busy && cur_tgt == TGT_TIMER);

    // unmapped addresses are answered here
    always_comb begin
        err_resp         = '0;
        err_resp.arready = 1'b1;
        err_resp.awready = arb_req.awvalid & arb_req.wvalid;
        err_resp.wready  = arb_req.awvalid & arb_req.wvalid;
        err_resp.rresp   = RESP_DECERR;
        err_resp.rvalid  = err_r;
        err_resp.bresp   = RESP_DECERR;
        err_resp.bvalid  = err_b;
    end

    always_comb begin
        case (cur_tgt)
            TGT_SRAM:  mux_resp = sram_resp;
            TGT_TIMER: mux_resp = timer_resp;
            default:   mux_resp = err_resp;
        endcase
        arb_resp = mux_resp;
        if (busy) begin
            arb_resp.arready = 1'b0;
            arb_resp.awready = 1'b0;
            arb_resp.wready  = 1'b0;
        end else begin
            arb_resp.rvalid = 1'b0;
            arb_resp.bvalid = 1'b0;
        end
    end

    assign ar_hs  = !busy && arb_req.arvalid && arb_resp.arready;
    assign aw_hs  = !busy && arb_req.awvalid && arb_resp.awready;
    assign rsp_hs = busy && ((arb_resp.rvalid && arb_req.rready) ||
                             (arb_resp.bvalid && arb_req.bready));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            sel   <= TGT_SRAM;
            err_r <= 1'b0;
            err_b <= 1'b0;
        end else if (rsp_hs) begin
            busy  <= 1'b0;
            err_r <= 1'b0;
            err_b <= 1'b0;
        end else if (ar_hs || aw_hs) begin
            busy  <= 1'b1;
            sel   <= cur_tgt;
            err_r <= ar_hs && cur_tgt == TGT_ERR;
            err_b <= aw_hs && cur_tgt == TGT_ERR;
        end
    end

endmodule

`default_nettype wire

// File: hw/sram_slave.sv
`timescale 1ns/10ps
`default_nettype none

`include "bus_cfg.svh"

module sram_slave (
    input  logic               clk,
    input  logic               rst_n,
    input  bus_pkg::axi_req_t  req,
    output bus_pkg::axi_resp_t resp
);

    import bus_pkg::*;

    localparam int OFS_W = $clog2(`BUS_STRB_W);
    localparam int IDX_W = $clog2(`SRAM_WORDS);

    data_t            mem [`SRAM_WORDS];
    data_t            rdata_q;
    logic             r_pend;
    logic             b_pend;
    logic             ar_hs;
    logic             wr_en;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    // word index sits above the byte offset
    assign rd_idx = req.araddr[OFS_W +: IDX_W];
    assign wr_idx = req.awaddr[OFS_W +: IDX_W];

    assign ar_hs = req.arvalid & ~r_pend;
    // aw and w are taken in the same cycle
    assign wr_en = req.awvalid & req.wvalid & ~b_pend;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < `BUS_STRB_W; b++) begin
                if (req.wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
        if (ar_hs) begin
            rdata_q <= mem[rd_idx];
        end
    end

    // pending flags keep each response up until accepted
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_pend <= 1'b0;
            b_pend <= 1'b0;
        end else begin
            if (ar_hs) begin
                r_pend <= 1'b1;
            end else if (req.rready) begin
                r_pend <= 1'b0;
            end
            if (wr_en) begin
                b_pend <= 1'b1;
            end else if (req.bready) begin
                b_pend <= 1'b0;
            end
        end
    end

    always_comb begin
        resp         = '0;
        resp.arready = ~r_pend;
        resp.rdata   = rdata_q;
        resp.rresp   = RESP_OKAY;
        resp.rvalid  = r_pend;
        resp.awready = wr_en;
        resp.wready  = wr_en;
        resp.bresp   = RESP_OKAY;
        resp.bvalid  = b_pend;
    end

endmodule

`default_nettype wire

// File: hw/timer_slave.sv
`timescale 1ns/10ps
`default_nettype none

`include "bus_cfg.svh"

module timer_slave (
    input  logic               clk,
    input  logic               rst_n,
    input  bus_pkg::axi_req_t  req,
    output bus_pkg::axi_resp_t resp
);

    import bus_pkg::*;

    data_t count_q;
    logic  enable_q;
    data_t rdata_q;
    logic  r_pend;
    logic  b_pend;
    logic  ar_hs;
    logic  wr_en;
    logic  rd_ctrl;
    logic  wr_count;
    logic  wr_ctrl;

    assign ar_hs = req.arvalid & ~r_pend;
    assign wr_en = req.awvalid & req.wvalid & ~b_pend;

    // register select from the low address bits
    assign rd_ctrl  = req.araddr[3:0] == `TIMER_CTRL_OFS;
    assign wr_count = wr_en && req.awaddr[3:0] == `TIMER_COUNT_OFS;
    assign wr_ctrl  = wr_en && req.awaddr[3:0] == `TIMER_CTRL_OFS;

    // a load wins over the increment
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q  <= '0;
            enable_q <= 1'b1;
        end else begin
            if (wr_count) begin
                count_q <= req.wdata;
            end else if (enable_q) begin
                count_q <= count_q + 1'b1;
            end
            if (wr_ctrl) begin
                enable_q <= req.wdata[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata_q <= rd_ctrl ? data_t'(enable_q) : count_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_pend <= 1'b0;
            b_pend <= 1'b0;
        end else begin
            r_pend <= ar_hs | (r_pend & ~req.rready);
            b_pend <= wr_en | (b_pend & ~req.bready);
        end
    end

    always_comb begin
        resp         = '0;
        resp.arready = ~r_pend;
        resp.rdata   = rdata_q;
        resp.rresp   = RESP_OKAY;
        resp.rvalid  = r_pend;
        resp.awready = wr_en;
        resp.wready  = wr_en;
        resp.bresp   = RESP_OKAY;
        resp.bvalid  = b_pend;
    end

endmodule

`default_nettype wire

// File: hw/mem_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys (
    input  logic               clk,
    input  logic               rst_n,
    input  bus_pkg::axi_req_t  fetch_req,
    output bus_pkg::axi_resp_t fetch_resp,
    input  bus_pkg::axi_req_t  lsu_req,
    output bus_pkg::axi_resp_t lsu_resp
);

    import bus_pkg::*;

    axi_req_t  arb_req;
    axi_resp_t arb_resp;
    axi_req_t  sram_req;
    axi_resp_t sram_resp;
    axi_req_t  timer_req;
    axi_resp_t timer_resp;

    // two masters onto one bus
    bus_arbiter i_bus_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .fetch_resp (fetch_resp),
        .lsu_req    (lsu_req),
        .lsu_resp   (lsu_resp),
        .arb_req    (arb_req),
        .arb_resp   (arb_resp)
    );

    // address map and decode errors
    bus_xbar i_bus_xbar (
        .clk        (clk),
        .rst_n      (rst_n),
        .arb_req    (arb_req),
        .arb_resp   (arb_resp),
        .sram_req   (sram_req),
        .sram_resp  (sram_resp),
        .timer_req  (timer_req),
        .timer_resp (timer_resp)
    );

    sram_slave i_sram_slave (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (sram_req),
        .resp  (sram_resp)
    );

    timer_slave i_timer_slave (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (timer_req),
        .resp  (timer_resp)
    );

endmodule

`default_nettype wire

// File: dv/tb_mem_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsys;

    import bus_pkg::*;

    localparam int COLS       = 8;
    localparam int MAX_LINES  = 64;
    localparam int CLK_HALF   = 2;
    localparam int DRIVE_DLY  = 1;
    localparam int RST_CYCLES = 4;
    localparam int LINE_LIMIT = 40;

    // golden columns
    localparam int C_MASTER = 0;
    localparam int C_OP     = 1;
    localparam int C_ADDR   = 2;
    localparam int C_WDATA  = 3;
    localparam int C_STRB   = 4;
    localparam int C_EXP    = 5;
    localparam int C_RESP   = 6;
    localparam int C_FLAG   = 7;

    localparam logic [31:0] FLAG_PAIR = 32'h1;
    localparam logic [31:0] FLAG_RISE = 32'h2;

    logic        clk;
    logic        rst_n;
    axi_req_t    mreq [2];
    axi_resp_t   mresp [2];
    axi_req_t    fetch_req;
    axi_resp_t   fetch_resp;
    axi_req_t    lsu_req;
    axi_resp_t   lsu_resp;
    logic [31:0] golden [COLS*MAX_LINES];
    logic [31:0] rng_state;
    logic [31:0] last_rdata;
    int          n_lines;
    int          cycle = 0;
    int          cycle_limit = 0;

    // index 0 is the fetch port and index 1 the load/store port
    assign fetch_req = mreq[0];
    assign lsu_req   = mreq[1];
    assign mresp[0]  = fetch_resp;
    assign mresp[1]  = lsu_resp;

    mem_subsys i_mem_subsys (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .fetch_resp (fetch_resp),
        .lsu_req    (lsu_req),
        .lsu_resp   (lsu_resp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    function automatic logic [31:0] gold(input int row, input int col);
        return golden[row*COLS + col];
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_values(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle_limit > 0 && cycle > cycle_limit) begin
            abort_run($sformatf("timeout: the run went past its limit of %0d cycles",
                                cycle_limit));
        end
    end

    task automatic issue_read(input int m, input int row);
        mreq[m].araddr  = gold(row, C_ADDR);
        mreq[m].arvalid = 1'b1;
        @(negedge clk);
        while (!mresp[m].arready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DLY;
        mreq[m].arvalid = 1'b0;
    endtask

    // aw and w go up together
    task automatic issue_write(input int row);
        mreq[1].awaddr  = gold(row, C_ADDR);
        mreq[1].wdata   = gold(row, C_WDATA);
        mreq[1].wstrb   = strb_t'(gold(row, C_STRB));
        mreq[1].awvalid = 1'b1;
        mreq[1].wvalid  = 1'b1;
        @(negedge clk);
        while (!(mresp[1].awready && mresp[1].wready)) begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DLY;
        mreq[1].awvalid = 1'b0;
        mreq[1].wvalid  = 1'b0;
    endtask

    // response held through a random rready or bready stall
    task automatic await_response(input int m, input bit wr, input string name,
                                  output logic [31:0] data, output logic [1:0] resp,
                                  output int done_cycle);
        int stall;
        int k;
        rng_state = xorshift32(rng_state);
        stall = int'(rng_state[1:0]);
        @(negedge clk);
        while (!(wr ? mresp[m].bvalid : mresp[m].rvalid)) begin
            @(negedge clk);
        end
        data = wr ? 32'h0 : mresp[m].rdata;
        resp = wr ? mresp[m].bresp : mresp[m].rresp;
        for (k = 0; k <= stall; k++) begin
            if (k == stall) begin
                @(posedge clk);
                #DRIVE_DLY;
                mreq[m].rready = !wr;
                mreq[m].bready = wr;
            end
            @(negedge clk);
            compare_values({name, " held valid"}, 32'h1,
                           wr ? mresp[m].bvalid : mresp[m].rvalid);
            compare_values({name, " held data"}, data, wr ? 32'h0 : mresp[m].rdata);
            compare_values({name, " held resp"}, resp, wr ? mresp[m].bresp : mresp[m].rresp);
            compare_values("fetch write channel idle", 32'h0,
                           {mresp[0].awready, mresp[0].wready, mresp[0].bresp,
                            mresp[0].bvalid});
        end
        @(posedge clk);
        #DRIVE_DLY;
        done_cycle = cycle;
        mreq[m].rready = 1'b0;
        mreq[m].bready = 1'b0;
    endtask

    task automatic check_result(input int row, input logic [31:0] data,
                                input logic [1:0] resp);
        string name;
        name = $sformatf("txn %0d", row);
        compare_values({name, " resp"}, gold(row, C_RESP), {30'h0, resp});
        if (gold(row, C_OP) == 0) begin
            if ((gold(row, C_FLAG) & FLAG_RISE) != 0) begin
                compare_values({name, " count above bound"}, 32'h1, data > gold(row, C_EXP));
                compare_values({name, " count above last"}, 32'h1, data > last_rdata);
            end else begin
                compare_values({name, " rdata"}, gold(row, C_EXP), data);
            end
            last_rdata = data;
        end
    endtask

    task automatic fetch_read(input int row, output int done_cycle);
        logic [31:0] data;
        logic [1:0]  resp;
        if (gold(row, C_OP) != 0) begin
            abort_run($sformatf("txn %0d asks the read-only fetch port to write", row));
        end else begin
            issue_read(0, row);
            await_response(0, 1'b0, $sformatf("txn %0d", row), data, resp, done_cycle);
            check_result(row, data, resp);
        end
    endtask

    task automatic lsu_access(input int row, output int done_cycle);
        logic [31:0] data;
        logic [1:0]  resp;
        if (gold(row, C_OP) != 0) begin
            issue_write(row);
            await_response(1, 1'b1, $sformatf("txn %0d", row), data, resp, done_cycle);
        end else begin
            issue_read(1, row);
            await_response(1, 1'b0, $sformatf("txn %0d", row), data, resp, done_cycle);
        end
        check_result(row, data, resp);
    endtask

    // both address valids rise together and load/store must finish first
    task automatic run_pair(input int row);
        int lsu_row;
        int fetch_row;
        int t_lsu;
        int t_fetch;
        if (row + 1 >= n_lines || gold(row, C_MASTER) == gold(row + 1, C_MASTER)) begin
            abort_run($sformatf("txn %0d is paired but not with the other master", row));
        end else begin
            lsu_row   = (gold(row, C_MASTER) == 1) ? row : row + 1;
            fetch_row = (lsu_row == row) ? row + 1 : row;
            fork
                fetch_read(fetch_row, t_fetch);
                lsu_access(lsu_row, t_lsu);
            join
            compare_values($sformatf("txn %0d lsu before fetch", row), 32'h1, t_lsu < t_fetch);
        end
    endtask

    initial begin
        int row;
        int t_done;
        rst_n      = 1'b0;
        mreq[0]    = '0;
        mreq[1]    = '0;
        rng_state  = 32'd85598;
        last_rdata = '0;
        // all ones marks rows the file leaves empty
        for (int i = 0; i < COLS*MAX_LINES; i++) begin
            golden[i] = '1;
        end
        $readmemh("dv/mem_golden.txt", golden);
        n_lines = 0;
        while (n_lines < MAX_LINES && gold(n_lines, C_MASTER) != 32'hffff_ffff) begin
            n_lines++;
        end
        if (n_lines == 0) begin
            abort_run("the golden file holds no transactions");
        end
        cycle_limit = LINE_LIMIT * n_lines + RST_CYCLES;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        row = 0;
        while (row < n_lines) begin
            if ((gold(row, C_FLAG) & FLAG_PAIR) != 0) begin
                run_pair(row);
                row += 2;
            end else if (gold(row, C_MASTER) == 0) begin
                fetch_read(row, t_done);
                row += 1;
            end else begin
                lsu_access(row, t_done);
                row += 1;
            end
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/mem_golden.txt
// master(0 fetch, 1 lsu) op(0 read, 1 write) addr wdata strb exp_rdata exp_resp flag
// flag 1 issues the line with the next one, flag 2 wants a count above exp_rdata and the last read
// sram writes with byte strobes
1 1 00000040 11223344 f 00000000 0 0
1 1 00000040 aabbccdd 5 00000000 0 0
1 0 00000040 00000000 0 11bb33dd 0 0
1 1 00000040 eeff0000 c 00000000 0 0
1 0 00000040 00000000 0 eeff33dd 0 0
1 1 00000044 cafef00d f 00000000 0 0
1 1 000003fc 0badbeef f 00000000 0 0
1 1 000003fc 12345678 2 00000000 0 0
1 0 000003fc 00000000 0 0bad56ef 0 0
// fetch reads of the same words
0 0 00000044 00000000 0 cafef00d 0 0
0 0 00000040 00000000 0 eeff33dd 0 0
// both masters in the same cycle
0 0 00000044 00000000 0 cafef00d 0 1
1 0 000003fc 00000000 0 0bad56ef 0 0
1 1 00000080 01020304 f 00000000 0 1
0 0 000003fc 00000000 0 0bad56ef 0 0
1 0 00000080 00000000 0 01020304 0 0
// timer stopped, loaded, then restarted
1 1 10000004 00000000 f 00000000 0 0
1 1 10000000 00001000 f 00000000 0 0
1 0 10000000 00000000 0 00001000 0 0
1 0 10000004 00000000 0 00000000 0 0
1 1 10000004 00000001 f 00000000 0 0
1 0 10000000 00000000 0 00001000 0 2
0 0 10000000 00000000 0 00001000 0 2
0 0 10000004 00000000 0 00000001 0 0
// unmapped addresses
1 0 20000000 00000000 0 00000000 3 0
1 1 20000000 deadbeef f 00000000 3 0
0 0 30000000 00000000 0 00000000 3 0
1 1 20000010 12345678 f 00000000 3 1
0 0 00000080 00000000 0 01020304 0 0

// File: src.f
+incdir+hw
hw/bus_pkg.sv
hw/bus_arbiter.sv
hw/bus_xbar.sv
hw/sram_slave.sv
hw/timer_slave.sv
hw/mem_subsys.sv
dv/tb_mem_subsys.sv

// File: Bender.yml
package:
  name: mem_subsys

export_include_dirs:
  - hw

sources:
  - hw/bus_pkg.sv
  - hw/bus_arbiter.sv
  - hw/bus_xbar.sv
  - hw/sram_slave.sv
  - hw/timer_slave.sv
  - hw/mem_subsys.sv
  - target: test
    files:
      - dv/tb_mem_subsys.sv
